// ==== include/chroma_consts.svh ====
// Chroma prediction constants
`ifndef CHROMA_CONSTS_SVH
`define CHROMA_CONSTS_SVH

// Pixel and fraction widths
`define PEL_W 8
`define FRAC_W 3

// Output block side and reference area side
`define BLK_DIM 4
`define REF_DIM 5

// Bilinear result rounding
// Weights sum to 64, so round with half of it
`define PRED_ROUND 32
`define PRED_SHIFT 6

`endif

// ==== logic/chroma_pred_pkg.sv ====
// Chroma prediction shared types
`include "chroma_consts.svh"

package chroma_pred_pkg;

	// ----------------------------------------------------------------------
	// Scalars
	// ----------------------------------------------------------------------
	typedef logic [`PEL_W-1:0]  pel_t;
	typedef logic [`FRAC_W-1:0] frac_t;
	typedef logic [1:0]         tile_idx_t;

	// Motion vector fraction in eighth-pel steps
	typedef struct packed {
		frac_t xfrac;
		frac_t yfrac;
	} mc_frac_t;

	// ----------------------------------------------------------------------
	// Pixel groups, element 0 is the leftmost / topmost pixel
	// ----------------------------------------------------------------------
	typedef pel_t [`REF_DIM-1:0] ref_row_t;

	// Indexed as [row][col]
	typedef pel_t [2:0][2:0] window_t;

	typedef pel_t [`BLK_DIM*`BLK_DIM-1:0] pred_block_t;

	// ----------------------------------------------------------------------
	// Tile strobes
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic      valid;
		tile_idx_t tile_idx;
	} tile_req_t;

	// Four tile pixels in raster order
	typedef struct packed {
		logic       valid;
		tile_idx_t  tile_idx;
		pel_t [3:0] pel;
	} pred_tile_t;

endpackage

// ==== logic/chroma_pred_ctrl.sv ====
// Chroma prediction control FSM
`timescale 1ns/1ns
`include "chroma_consts.svh"

module chroma_pred_ctrl (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       start,
	input  chroma_pred_pkg::mc_frac_t  mc_frac,
	input  logic                       ref_valid,
	output logic                       row_we,
	output logic [2:0]                 row_sel,
	output chroma_pred_pkg::mc_frac_t  frac,
	output chroma_pred_pkg::tile_req_t tile_req
);
	import chroma_pred_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_ISSUE
	} state_t;

	state_t    state;
	logic [2:0] row_cnt;
	tile_idx_t tile_cnt;
	mc_frac_t  frac_q;

	// ----------------------------------------------------------------------
	// State and counters
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= ST_IDLE;
			row_cnt  <= '0;
			tile_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state   <= ST_LOAD;
						row_cnt <= '0;
					end
				end
				ST_LOAD: begin
					if (ref_valid) begin
						row_cnt <= row_cnt + 3'd1;
						// Last reference row written this cycle
						if (row_cnt == 3'(`REF_DIM - 1)) begin
							state    <= ST_ISSUE;
							tile_cnt <= '0;
						end
					end
				end
				ST_ISSUE: begin
					tile_cnt <= tile_cnt + 2'd1;
					if (tile_cnt == 2'd3)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Fraction held for the whole block
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start)
			frac_q <= mc_frac;
	end

	// ----------------------------------------------------------------------
	// Outputs
	// ----------------------------------------------------------------------
	assign row_we            = (state == ST_LOAD) && ref_valid;
	assign row_sel           = row_cnt;
	assign frac              = frac_q;
	assign tile_req.valid    = (state == ST_ISSUE);
	assign tile_req.tile_idx = tile_cnt;

endmodule

// ==== logic/ref_window_buffer.sv ====
// Reference area buffer with window select
`timescale 1ns/1ns
`include "chroma_consts.svh"

module ref_window_buffer (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       row_we,
	input  logic [2:0]                 row_sel,
	input  chroma_pred_pkg::ref_row_t  ref_row,
	input  chroma_pred_pkg::tile_req_t tile_req,
	output chroma_pred_pkg::window_t   window
);
	import chroma_pred_pkg::*;

	ref_row_t   ref_q [`REF_DIM];
	logic [1:0] row0;
	logic [1:0] col0;

	// ----------------------------------------------------------------------
	// Reference rows, one per strobe
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < `REF_DIM; r++)
				ref_q[r] <= '0;
		end else if (row_we) begin
			ref_q[row_sel] <= ref_row;
		end
	end

	// ----------------------------------------------------------------------
	// Window select
	// ----------------------------------------------------------------------
	// Tiles are 2x2, so neighbouring windows overlap by one row or column
	assign row0 = {tile_req.tile_idx[1], 1'b0};
	assign col0 = {tile_req.tile_idx[0], 1'b0};

	always_comb begin
		window = '0;
		// Quiet window between tiles
		if (tile_req.valid) begin
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					window[r][c] = ref_q[int'(row0) + r][int'(col0) + c];
				end
			end
		end
	end

endmodule

// ==== logic/chroma_bilinear_pe.sv ====
// Bilinear chroma processing element
`timescale 1ns/1ns
`include "chroma_consts.svh"

module chroma_bilinear_pe (
	input  chroma_pred_pkg::mc_frac_t frac,
	input  chroma_pred_pkg::pel_t     a,
	input  chroma_pred_pkg::pel_t     b,
	input  chroma_pred_pkg::pel_t     c,
	input  chroma_pred_pkg::pel_t     d,
	output chroma_pred_pkg::pel_t     pel
);
	// Weighted sum fits pixel width plus two fraction widths
	localparam int SUM_W = `PEL_W + 2 * `FRAC_W;
	localparam int WGT_W = `FRAC_W + 1;

	logic [WGT_W-1:0] wx;
	logic [WGT_W-1:0] wy;
	logic [WGT_W-1:0] wx_n;
	logic [WGT_W-1:0] wy_n;
	logic [SUM_W-1:0] sum;

	// Pixel times wx times wy from shifted partial products
	function automatic logic [SUM_W-1:0] weigh(
		input logic [`PEL_W-1:0] p,
		input logic [WGT_W-1:0]  w_x,
		input logic [WGT_W-1:0]  w_y
	);
		logic [SUM_W-1:0] acc_x;
		logic [SUM_W-1:0] acc_y;
		acc_x = '0;
		acc_y = '0;
		for (int i = 0; i < WGT_W; i++) begin
			if (w_x[i])
				acc_x = acc_x + (SUM_W'(p) << i);
		end
		for (int i = 0; i < WGT_W; i++) begin
			if (w_y[i])
				acc_y = acc_y + (acc_x << i);
		end
		return acc_y;
	endfunction

	// Complement weights, 8 - x and 8 - y
	assign wx   = {1'b0, frac.xfrac};
	assign wy   = {1'b0, frac.yfrac};
	assign wx_n = WGT_W'(1 << `FRAC_W) - wx;
	assign wy_n = WGT_W'(1 << `FRAC_W) - wy;

	assign sum = (weigh(a, wx_n, wy_n) + weigh(b, wx, wy_n))
	           + (weigh(c, wx_n, wy) + weigh(d, wx, wy))
	           + SUM_W'(`PRED_ROUND);

	assign pel = sum[`PRED_SHIFT +: `PEL_W];

endmodule

// ==== logic/chroma_bilinear_array.sv ====
// Four element bilinear array on a 3x3 window
`timescale 1ns/1ns

module chroma_bilinear_array (
	input  logic                        clk,
	input  logic                        arst_n,
	input  chroma_pred_pkg::mc_frac_t   frac,
	input  chroma_pred_pkg::window_t    window,
	input  chroma_pred_pkg::tile_req_t  tile_req,
	output chroma_pred_pkg::pred_tile_t pred_tile
);
	import chroma_pred_pkg::*;

	pel_t [3:0] pe_pel;
	pel_t [3:0] pel_q;
	tile_idx_t  idx_q;
	logic       valid_q;

	// ----------------------------------------------------------------------
	// Elements, one per tile pixel in raster order
	// ----------------------------------------------------------------------
	// Element k takes the 2x2 neighbourhood whose top left is (k/2, k%2)
	for (genvar k = 0; k < 4; k++) begin : g_pe
		localparam int R = k / 2;
		localparam int C = k % 2;

		chroma_bilinear_pe i_pe (
			.frac (frac),
			.a    (window[R][C]),
			.b    (window[R][C+1]),
			.c    (window[R+1][C]),
			.d    (window[R+1][C+1]),
			.pel  (pe_pel[k])
		);
	end

	// ----------------------------------------------------------------------
	// Output register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= tile_req.valid;
	end

	always_ff @(posedge clk) begin
		pel_q <= pe_pel;
		idx_q <= tile_req.tile_idx;
	end

	assign pred_tile.valid    = valid_q;
	assign pred_tile.tile_idx = idx_q;
	assign pred_tile.pel      = pel_q;

endmodule

// ==== logic/pred_block_assembler.sv ====
// Prediction block assembler
`timescale 1ns/1ns
`include "chroma_consts.svh"

module pred_block_assembler (
	input  logic                         clk,
	input  logic                         arst_n,
	input  chroma_pred_pkg::pred_tile_t  pred_tile,
	output chroma_pred_pkg::pred_block_t pred_block,
	output logic                         done
);
	import chroma_pred_pkg::*;

	pred_block_t blk_q;
	logic        last_q;
	logic [1:0]  row0;
	logic [1:0]  col0;

	assign row0 = {pred_tile.tile_idx[1], 1'b0};
	assign col0 = {pred_tile.tile_idx[0], 1'b0};

	// ----------------------------------------------------------------------
	// Tile storage
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (pred_tile.valid) begin
			for (int k = 0; k < 4; k++)
				blk_q[(int'(row0) + k / 2) * `BLK_DIM + int'(col0) + k % 2] <= pred_tile.pel[k];
		end
	end

	// ----------------------------------------------------------------------
	// Block output and done
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_q     <= 1'b0;
			done       <= 1'b0;
			pred_block <= '0;
		end else begin
			// Tile 3 is always the last of a block
			last_q <= pred_tile.valid && (pred_tile.tile_idx == 2'd3);
			done   <= last_q;
			if (last_q)
				pred_block <= blk_q;
		end
	end

endmodule

// ==== logic/chroma_inter_pred.sv ====
// Chroma inter prediction top level
`timescale 1ns/1ns

module chroma_inter_pred (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         start,
	input  chroma_pred_pkg::mc_frac_t    mc_frac,
	input  logic                         ref_valid,
	input  chroma_pred_pkg::ref_row_t    ref_row,
	output chroma_pred_pkg::pred_block_t pred_block,
	output logic                         done
);
	import chroma_pred_pkg::*;

	logic       row_we;
	logic [2:0] row_sel;
	mc_frac_t   frac;
	tile_req_t  tile_req;
	window_t    window;
	pred_tile_t pred_tile;

	// ----------------------------------------------------------------------
	// Control
	// ----------------------------------------------------------------------
	chroma_pred_ctrl i_chroma_pred_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.mc_frac   (mc_frac),
		.ref_valid (ref_valid),
		.row_we    (row_we),
		.row_sel   (row_sel),
		.frac      (frac),
		.tile_req  (tile_req)
	);

	// ----------------------------------------------------------------------
	// Datapath
	// ----------------------------------------------------------------------
	ref_window_buffer i_ref_window_buffer (
		.clk      (clk),
		.arst_n   (arst_n),
		.row_we   (row_we),
		.row_sel  (row_sel),
		.ref_row  (ref_row),
		.tile_req (tile_req),
		.window   (window)
	);

	chroma_bilinear_array i_chroma_bilinear_array (
		.clk       (clk),
		.arst_n    (arst_n),
		.frac      (frac),
		.window    (window),
		.tile_req  (tile_req),
		.pred_tile (pred_tile)
	);

	pred_block_assembler i_pred_block_assembler (
		.clk        (clk),
		.arst_n     (arst_n),
		.pred_tile  (pred_tile),
		.pred_block (pred_block),
		.done       (done)
	);

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock generator
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS = 100
) (
	output logic clk
);
	initial clk = 1'b0;

	// Free running, first rising edge half a period in
	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== tests/chroma_inter_pred_tb.sv ====
// Chroma inter prediction testbench
`timescale 1ns/1ns
`include "chroma_consts.svh"

module chroma_inter_pred_tb;
	import chroma_pred_pkg::*;

	localparam int DRIVE_DLY  = 10;
	localparam int RST_CYCLES = 16;

	typedef enum logic [1:0] {
		PAT_CONST,
		PAT_RAMP,
		PAT_RANDOM,
		PAT_CHECKER
	} pat_t;

	// One table row, expected block is derived per case
	typedef struct packed {
		frac_t      xfrac;
		frac_t      yfrac;
		pat_t       kind;
		pel_t       level;
		logic [1:0] gaps;
		logic       spurious;
	} case_t;

	logic        clk;
	logic        arst_n;
	logic        start;
	mc_frac_t    mc_frac;
	logic        ref_valid;
	ref_row_t    ref_row;
	pred_block_t pred_block;
	logic        done;

	case_t       cases [$];
	pred_block_t want_q [$];
	int          want_edge_q [$];
	pel_t        area [`REF_DIM][`REF_DIM];
	int          edge_cnt = 0;
	integer      seed = 32'h2c4f;
	logic        table_ready = 1'b0;

	tb_clock_gen #(.PERIOD_NS(100)) i_tb_clock_gen (.clk(clk));

	chroma_inter_pred i_chroma_inter_pred (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.mc_frac    (mc_frac),
		.ref_valid  (ref_valid),
		.ref_row    (ref_row),
		.pred_block (pred_block),
		.done       (done)
	);

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_val(input string name, input logic [127:0] got,
	                         input logic [127:0] want);
		if (got !== want)
			abort_run($sformatf("FAILED at %0t ns: %s = %0h, expected %0h",
			                    $time, name, got, want));
	endtask

	task automatic step();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	function automatic case_t make_case(input int x, input int y, input pat_t kind,
	                                    input int level, input int gaps, input bit spurious);
		case_t tc;
		tc.xfrac    = frac_t'(x);
		tc.yfrac    = frac_t'(y);
		tc.kind     = kind;
		tc.level    = pel_t'(level);
		tc.gaps     = 2'(gaps);
		tc.spurious = spurious;
		return tc;
	endfunction

	// Bilinear rule in plain integers, weights sum to 64
	function automatic pel_t interp_pel(input int x, input int y, input int a, input int b,
	                                    input int c, input int d);
		int acc;
		acc = (8 - x) * (8 - y) * a + x * (8 - y) * b + (8 - x) * y * c + x * y * d;
		return pel_t'((acc + `PRED_ROUND) >> `PRED_SHIFT);
	endfunction

	task automatic build_table();
		cases.push_back(make_case(0, 0, PAT_RAMP, 0, 0, 1'b0));
		cases.push_back(make_case(7, 0, PAT_RAMP, 0, 1, 1'b0));
		cases.push_back(make_case(0, 7, PAT_RAMP, 0, 2, 1'b1));
		cases.push_back(make_case(7, 7, PAT_CHECKER, 0, 0, 1'b0));
		cases.push_back(make_case(3, 5, PAT_CONST, 0, 0, 1'b1));
		cases.push_back(make_case(5, 3, PAT_CONST, 255, 3, 1'b1));
		cases.push_back(make_case(7, 7, PAT_CONST, 255, 0, 1'b0));
		cases.push_back(make_case(4, 4, PAT_CONST, 77, 1, 1'b0));
		cases.push_back(make_case(1, 6, PAT_RANDOM, 0, 3, 1'b1));
		// Every fraction pair, mostly random pixels
		for (int i = 0; i < 64; i++)
			cases.push_back(make_case(i % 8, i / 8, (i % 6 == 5) ? PAT_CHECKER : PAT_RANDOM,
			                          0, i % 4, (i % 5) == 0));
	endtask

	// Reference area and expected block for one case
	task automatic fill_area(input case_t tc, output pred_block_t want);
		int r;
		int c;
		for (int i = 0; i < `REF_DIM * `REF_DIM; i++) begin
			r = i / `REF_DIM;
			c = i % `REF_DIM;
			case (tc.kind)
				PAT_CONST:  area[r][c] = tc.level;
				PAT_RAMP:   area[r][c] = pel_t'(r * 48 + c * 9 + 3);
				PAT_RANDOM: area[r][c] = pel_t'($random(seed));
				default:    area[r][c] = ((r + c) % 2 == 1) ? 8'd255 : 8'd0;
			endcase
		end
		for (int k = 0; k < `BLK_DIM * `BLK_DIM; k++) begin
			r = k / `BLK_DIM;
			c = k % `BLK_DIM;
			if (tc.kind == PAT_CONST)
				want[k] = tc.level;
			else if (tc.xfrac == 0 && tc.yfrac == 0)
				want[k] = area[r][c];
			else
				want[k] = interp_pel(tc.xfrac, tc.yfrac, area[r][c], area[r][c+1],
				                     area[r+1][c], area[r+1][c+1]);
		end
	endtask

	task automatic run_case(input case_t tc);
		pred_block_t want;
		fill_area(tc, want);
		start         = 1'b1;
		mc_frac.xfrac = tc.xfrac;
		mc_frac.yfrac = tc.yfrac;
		step();
		start = 1'b0;
		for (int r = 0; r < `REF_DIM; r++) begin
			if (r > 0) begin
				ref_valid = 1'b0;
				repeat (tc.gaps) step();
			end
			ref_valid = 1'b1;
			for (int c = 0; c < `REF_DIM; c++)
				ref_row[c] = area[r][c];
			// Busy start with another fraction
			if (tc.spurious && r == 2) begin
				start   = 1'b1;
				mc_frac = mc_frac_t'(~mc_frac);
			end
			// Fifth row lands on the next edge, done six edges later
			if (r == `REF_DIM - 1) begin
				want_q.push_back(want);
				want_edge_q.push_back(edge_cnt + 7);
			end
			step();
			start = 1'b0;
		end
		// Tiles are issued now, so this row is dropped
		ref_valid = tc.spurious;
		ref_row   = ~ref_row;
		step();
		ref_valid = 1'b0;
		repeat (3) step();
	endtask

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	initial begin : main
		arst_n    = 1'b0;
		start     = 1'b0;
		mc_frac   = '0;
		ref_valid = 1'b0;
		ref_row   = '0;
		build_table();
		table_ready = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		check_val("done", 128'(done), '0);
		check_val("pred_block", 128'(pred_block), '0);
		foreach (cases[i])
			run_case(cases[i]);
		while (want_q.size() != 0)
			step();
		// Room for a stray done pulse
		repeat (8) step();
		$display("Simulation finished: PASS");
		$finish;
	end

	// ----------------------------------------------------------------------
	// Result monitor and watchdog
	// ----------------------------------------------------------------------
	initial begin : monitor
		pred_block_t want;
		int          want_edge;
		wait (arst_n === 1'b1);
		forever begin
			step();
			if (done === 1'b1) begin
				if (want_q.size() == 0) begin
					abort_run("done pulsed while no block was outstanding");
				end else begin
					want      = want_q.pop_front();
					want_edge = want_edge_q.pop_front();
					check_val("done edge", 128'(edge_cnt), 128'(want_edge));
					for (int k = 0; k < `BLK_DIM * `BLK_DIM; k++)
						check_val($sformatf("pred_block[%0d]", k), 128'(pred_block[k]),
						          128'(want[k]));
				end
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (table_ready === 1'b1);
		limit = RST_CYCLES;
		foreach (cases[i])
			limit += `REF_DIM * (1 + int'(cases[i].gaps)) + 20;
		repeat (limit) @(posedge clk);
		abort_run("Timeout: done never arrived for all cases within the cycle limit");
	end

endmodule

// ==== flist.f ====
+incdir+include
logic/chroma_pred_pkg.sv
logic/chroma_pred_ctrl.sv
logic/ref_window_buffer.sv
logic/chroma_bilinear_pe.sv
logic/chroma_bilinear_array.sv
logic/pred_block_assembler.sv
logic/chroma_inter_pred.sv
tests/tb_clock_gen.sv
tests/chroma_inter_pred_tb.sv

// ==== Makefile ====
SIM     := verilator
FLAGS   := --binary --timing -Wno-fatal
TOP     := chroma_inter_pred_tb
FLIST   := flist.f
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Pass or fail is taken from the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
